// File: Bender.yml
package:
  name: cp0

export_include_dirs:
  - common

sources:
  - common/cp0Pkg.sv
  - timer/cp0Timer.sv
  - exception/cp0Exception.sv
  - verilog/cp0Interrupt.sv
  - verilog/cp0ReadMux.sv
  - verilog/cp0Top.sv
  - target: simulation
    files:
      - bench/cp0Tb.sv

// File: bench/cp0Tb.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0Tb
    import cp0Pkg::*;
;

    localparam int MaxCycles = 3000;   // Whole run needs a few hundred cycles

    logic     clk;
    logic     rstN;
    hwIrq_t   hwIrq;
    regAddr_t rdAddr;
    logic     wrEn;
    regAddr_t wrAddr;
    word_t    wrData;
    excType_t excType;
    word_t    excPc;
    logic     excInDelaySlot;
    word_t    excBadAddr;
    word_t    rdData;
    word_t    epc;
    logic     statusExl;
    logic     statusBev;
    logic     intPending;

    // Checker requests, set by the stimulus
    logic  chkRd;
    word_t expRd;
    logic  chkInt;
    logic  expInt;

    int errors;
    int checks;
    int cycles;

    excType_t kinds[10] = '{Interrupt, AdelIf, AdelMem, AdesMem, Syscall,
                            Break, ReservedInstr, CpU, Overflow, Trap};

    cp0Top UUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    rdCheck: assert property (@(posedge clk) disable iff (!rstN)
        chkRd |-> rdData == expRd)
        else begin
            errors++;
            $display("Fail rdData (reg %0d) expected %h actual %h",
                     $sampled(rdAddr), $sampled(expRd), $sampled(rdData));
        end

    intCheck: assert property (@(posedge clk) disable iff (!rstN)
        chkInt |-> intPending == expInt)
        else begin
            errors++;
            $display("Fail intPending expected %h actual %h",
                     $sampled(expInt), $sampled(intPending));
        end

    // Direct EPC output matches every expected EPC read
    epcOutCheck: assert property (@(posedge clk) disable iff (!rstN)
        chkRd && rdAddr == `CP0_REG_EPC |-> epc == expRd)
        else begin
            errors++;
            $display("Fail epc expected %h actual %h", $sampled(expRd), $sampled(epc));
        end

    exlOutCheck: assert property (@(posedge clk) disable iff (!rstN)
        chkRd && rdAddr == `CP0_REG_STATUS |-> statusExl == expRd[`STATUS_EXL])
        else begin
            errors++;
            $display("Fail statusExl expected %h actual %h",
                     $sampled(expRd[`STATUS_EXL]), $sampled(statusExl));
        end

    bevOutCheck: assert property (@(posedge clk) disable iff (!rstN)
        chkRd && rdAddr == `CP0_REG_STATUS |-> statusBev == expRd[`STATUS_BEV])
        else begin
            errors++;
            $display("Fail statusBev expected %h actual %h",
                     $sampled(expRd[`STATUS_BEV]), $sampled(statusBev));
        end

    // Architectural ExcCode for each exception kind
    function automatic excCode_t codeFor(input excType_t kind);
        case (kind)
            AdelIf, AdelMem: return `EXC_ADEL;
            AdesMem:         return `EXC_ADES;
            Syscall:         return `EXC_SYS;
            Break:           return `EXC_BP;
            ReservedInstr:   return `EXC_RI;
            CpU:             return `EXC_CPU;
            Overflow:        return `EXC_OV;
            Trap:            return `EXC_TR;
            default:         return `EXC_INT;
        endcase
    endfunction

    function automatic word_t causeWord(input logic bd, input logic ti, input logic [1:0] ce,
                                        input logic [7:0] ip, input excCode_t code);
        return {bd, ti, ce, 12'h000, ip, 1'b0, code, 2'b00};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic writeReg(input regAddr_t addr, input word_t data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        step();
        wrEn = 1'b0;
    endtask

    task automatic checkRead(input regAddr_t addr, input word_t exp);
        rdAddr = addr;
        expRd  = exp;
        chkRd  = 1'b1;
        checks++;
        step();
        chkRd = 1'b0;
    endtask

    task automatic checkInt(input logic exp);
        expInt = exp;
        chkInt = 1'b1;
        checks++;
        step();
        chkInt = 1'b0;
    endtask

    task automatic raiseExc(input excType_t kind, input word_t pc, input logic ds,
                            input word_t bad);
        excType        = kind;
        excPc          = pc;
        excInDelaySlot = ds;
        excBadAddr     = bad;
        step();
        excType = None;
    endtask

    initial begin
        word_t v;
        word_t pc;
        word_t bad;
        word_t s;
        word_t expEpc;
        word_t expBad;
        logic [1:0] expCe;
        logic ds;
        logic expBd;
        int n;
        int b;

        void'($urandom(31976));
        clk = 1'b0;
        rstN = 1'b0;
        hwIrq = '0;
        rdAddr = '0;
        wrEn = 1'b0;
        wrAddr = '0;
        wrData = '0;
        excType = None;
        excPc = '0;
        excInDelaySlot = 1'b0;
        excBadAddr = '0;
        chkRd = 1'b0;
        expRd = '0;
        chkInt = 1'b0;
        expInt = 1'b0;
        repeat (16) @(posedge clk);
        #2 rstN = 1'b1;

        // Reset state
        checkRead(`CP0_REG_STATUS, 32'h0040_0000);
        checkRead(`CP0_REG_CAUSE, 32'h0);
        checkInt(1'b0);

        // Port writes and read-back
        v = $urandom;
        writeReg(`CP0_REG_EPC, v);
        checkRead(`CP0_REG_EPC, v);
        v = $urandom | 32'h8000_0000;         // Far from the small count value
        writeReg(`CP0_REG_COMPARE, v);
        checkRead(`CP0_REG_COMPARE, v);
        v = $urandom;
        writeReg(`CP0_REG_STATUS, v);
        checkRead(`CP0_REG_STATUS, v & 32'h0040_FF03);
        writeReg(`CP0_REG_STATUS, 32'h0040_0000);
        v = $urandom;
        writeReg(`CP0_REG_CAUSE, v);
        checkRead(`CP0_REG_CAUSE, causeWord(1'b0, 1'b0, 2'b00, {6'b0, v[9:8]}, 5'h0));
        writeReg(`CP0_REG_CAUSE, 32'h0);
        writeReg(`CP0_REG_BADVADDR, $urandom);
        checkRead(`CP0_REG_BADVADDR, 32'h0);  // Not writable

        // Count runs at half rate
        v = $urandom;
        n = 1 + $urandom % 8;
        writeReg(`CP0_REG_COUNT, v);
        repeat (2 * n) step();
        checkRead(`CP0_REG_COUNT, v + n);

        // Timer match sets TI and IP7, Compare write clears TI
        writeReg(`CP0_REG_COUNT, v);
        writeReg(`CP0_REG_COMPARE, v + 32'd3);
        repeat (8) step();
        checkRead(`CP0_REG_CAUSE, causeWord(1'b0, 1'b1, 2'b00, 8'h80, 5'h0));
        writeReg(`CP0_REG_COMPARE, v + 32'h0010_0000);
        step();                                // IP7 follows TI a cycle later
        checkRead(`CP0_REG_CAUSE, causeWord(1'b0, 1'b0, 2'b00, 8'h00, 5'h0));

        // Exceptions, each followed by Eret
        expBad = '0;
        expCe  = 2'b00;
        foreach (kinds[i]) begin
            pc  = $urandom & 32'hFFFF_FFFC;
            ds  = $urandom % 2;
            bad = $urandom;
            raiseExc(kinds[i], pc, ds, bad);
            expEpc = ds ? pc - 32'd4 : pc;
            expBd  = ds;
            if (kinds[i] == CpU)
                expCe = 2'b01;
            if (kinds[i] == AdelIf)
                expBad = pc;
            else if (kinds[i] == AdelMem || kinds[i] == AdesMem)
                expBad = bad;
            checkRead(`CP0_REG_STATUS, 32'h0040_0002);
            checkRead(`CP0_REG_CAUSE, causeWord(expBd, 1'b0, expCe, 8'h00, codeFor(kinds[i])));
            checkRead(`CP0_REG_EPC, expEpc);
            checkRead(`CP0_REG_BADVADDR, expBad);
            raiseExc(Eret, $urandom, 1'b0, $urandom);
            checkRead(`CP0_REG_STATUS, 32'h0040_0000);
        end

        // Nested exception keeps EPC and BD
        pc = $urandom & 32'hFFFF_FFFC;
        raiseExc(Syscall, pc, 1'b0, $urandom);
        raiseExc(Break, $urandom & 32'hFFFF_FFFC, 1'b1, $urandom);
        checkRead(`CP0_REG_CAUSE, causeWord(1'b0, 1'b0, expCe, 8'h00, `EXC_BP));
        checkRead(`CP0_REG_EPC, pc);
        raiseExc(Eret, $urandom, 1'b0, $urandom);
        checkRead(`CP0_REG_STATUS, 32'h0040_0000);

        // Interrupt decision from a hardware line
        b = $urandom % 6;
        s = 32'h0040_0001 | (32'h1 << (b + 10));
        writeReg(`CP0_REG_STATUS, s);
        hwIrq = hwIrq_t'(1 << b);
        checkInt(1'b0);                        // Line not yet registered
        checkInt(1'b1);
        writeReg(`CP0_REG_STATUS, s & ~32'h1);
        checkInt(1'b0);                        // IE clear
        writeReg(`CP0_REG_STATUS, s | 32'h2);
        checkInt(1'b0);                        // EXL set
        writeReg(`CP0_REG_STATUS, s);
        checkInt(1'b1);
        hwIrq = '0;
        checkInt(1'b1);
        checkInt(1'b0);

        // Software interrupt through Cause
        writeReg(`CP0_REG_STATUS, 32'h0040_0101);
        writeReg(`CP0_REG_CAUSE, 32'h0000_0100);
        checkInt(1'b1);
        writeReg(`CP0_REG_CAUSE, 32'h0);
        checkInt(1'b0);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: common/cp0Pkg.sv
package cp0Pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // CP0 register number, select field not modelled
    typedef logic [4:0] regAddr_t;

    // Exception kinds reported by the pipeline
    typedef enum logic [4:0] {
        None,
        Interrupt,
        AdelIf,           // Fetch address error
        AdelMem,          // Load address error
        AdesMem,          // Store address error
        Syscall,
        Break,
        ReservedInstr,
        CpU,              // Coprocessor unusable
        Overflow,
        Trap,
        Eret,
        Refetch           // Replay only, no CP0 side effects
    } excType_t;

    // Architectural Cause.ExcCode
    typedef logic [4:0] excCode_t;

    // External interrupt lines, IP7..IP2
    typedef logic [5:0] hwIrq_t;

endpackage

// File: common/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_COUNT     5'd9
`define CP0_REG_COMPARE   5'd11
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14

`define EXC_INT   5'h00
`define EXC_ADEL  5'h04
`define EXC_ADES  5'h05
`define EXC_SYS   5'h08
`define EXC_BP    5'h09
`define EXC_RI    5'h0a
`define EXC_CPU   5'h0b
`define EXC_OV    5'h0c
`define EXC_TR    5'h0d

`define STATUS_BEV_RESET   1'b1
`define DELAY_SLOT_OFFSET  32'd4

// Field positions in the Status word
`define STATUS_BEV  22
`define STATUS_IM   15:8
`define STATUS_EXL  1
`define STATUS_IE   0

// Field positions in the Cause word
`define CAUSE_BD       31
`define CAUSE_TI       30
`define CAUSE_CE       29:28
`define CAUSE_IP       15:8
`define CAUSE_IP_SW    9:8
`define CAUSE_EXCCODE  6:2

`endif

// File: exception/cp0Exception.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0Exception
    import cp0Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       wrEn,
    input  regAddr_t   wrAddr,
    input  word_t      wrData,
    input  excType_t   excType,
    input  word_t      excPc,
    input  logic       excInDelaySlot,
    input  word_t      excBadAddr,
    output logic       exl,
    output logic       bd,
    output logic [1:0] ce,
    output excCode_t   excCode,
    output word_t      epc,
    output word_t      badVAddr
);

    logic     excValid;   // Any kind with CP0 side effects
    logic     excTake;    // Entering exception level
    logic     statusWr;
    logic     epcWr;
    excCode_t codeNext;

    assign excValid = (excType != None) && (excType != Refetch);
    assign excTake  = excValid && (excType != Eret);
    assign statusWr = wrEn && (wrAddr == `CP0_REG_STATUS);
    assign epcWr    = wrEn && (wrAddr == `CP0_REG_EPC);

    always_comb begin
        case (excType)
            Interrupt:     codeNext = `EXC_INT;
            AdelIf:        codeNext = `EXC_ADEL;
            AdelMem:       codeNext = `EXC_ADEL;
            AdesMem:       codeNext = `EXC_ADES;
            Syscall:       codeNext = `EXC_SYS;
            Break:         codeNext = `EXC_BP;
            ReservedInstr: codeNext = `EXC_RI;
            CpU:           codeNext = `EXC_CPU;
            Overflow:      codeNext = `EXC_OV;
            Trap:          codeNext = `EXC_TR;
            default:       codeNext = excCode;   // Eret, None, Refetch hold
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            exl <= 1'b0;
        else if (excValid)
            exl <= (excType != Eret);
        else if (statusWr)
            exl <= wrData[`STATUS_EXL];
    end

    // Nested exceptions leave BD, CE and EPC alone
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bd <= 1'b0;
            ce <= 2'b00;
        end else if (excTake && !exl) begin
            bd <= excInDelaySlot;
            if (excType == CpU)
                ce <= 2'b01;   // Only CP1 is unusable here
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            excCode <= '0;
        else
            excCode <= codeNext;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            epc <= '0;
        end else if (excTake) begin
            if (!exl)
                epc <= excInDelaySlot ? excPc - `DELAY_SLOT_OFFSET : excPc;
        end else if (epcWr) begin
            epc <= wrData;
        end
    end

    // Address errors only; read-only from the port
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            badVAddr <= '0;
        else if (excType == AdelIf)
            badVAddr <= excPc;
        else if (excType == AdelMem || excType == AdesMem)
            badVAddr <= excBadAddr;
    end

    excTypeKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(excType))
        else $error("excType is unknown");

endmodule

// File: project.f
+incdir+common
common/cp0Pkg.sv
timer/cp0Timer.sv
exception/cp0Exception.sv
verilog/cp0Interrupt.sv
verilog/cp0ReadMux.sv
verilog/cp0Top.sv
bench/cp0Tb.sv

// File: timer/cp0Timer.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0Timer
    import cp0Pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    output word_t    count,
    output word_t    compare,
    output logic     timerIrq
);

    logic half;        // Divider phase, Count steps when set
    logic countWr;
    logic compareWr;
    logic match;
    logic matchPrev;

    assign countWr   = wrEn && (wrAddr == `CP0_REG_COUNT);
    assign compareWr = wrEn && (wrAddr == `CP0_REG_COMPARE);
    assign match     = (count == compare);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            half  <= 1'b0;
            count <= '0;
        end else if (countWr) begin
            half  <= 1'b0;     // Restart divider on reload
            count <= wrData;
        end else begin
            half <= ~half;
            if (half)
                count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            compare <= '0;
        else if (compareWr)
            compare <= wrData;
    end

    // TI latches on a new match; both registers reset equal, so start as matched
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            matchPrev <= 1'b1;
            timerIrq  <= 1'b0;
        end else begin
            matchPrev <= match;
            if (compareWr)
                timerIrq <= 1'b0;      // Clear beats set
            else if (match && !matchPrev)
                timerIrq <= 1'b1;
        end
    end

    countStep: assert property (@(posedge clk) disable iff (!rstN)
        !countWr |=> (count == $past(count)) || (count == $past(count) + 32'd1))
        else $error("count moved by more than one without a write");

endmodule

// File: verilog/cp0Interrupt.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0Interrupt
    import cp0Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       wrEn,
    input  regAddr_t   wrAddr,
    input  word_t      wrData,
    input  hwIrq_t     hwIrq,
    input  logic       timerIrq,
    input  logic       exl,
    output logic [7:0] ip,
    output logic [7:0] im,
    output logic       ie,
    output logic       bev,
    output logic       intPending
);

    logic   statusWr;
    logic   causeWr;
    hwIrq_t ipHw;        // IP7..IP2
    logic [1:0] ipSw;    // IP1..IP0

    assign statusWr = wrEn && (wrAddr == `CP0_REG_STATUS);
    assign causeWr  = wrEn && (wrAddr == `CP0_REG_CAUSE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bev <= `STATUS_BEV_RESET;
            im  <= '0;
            ie  <= 1'b0;
        end else if (statusWr) begin
            bev <= wrData[`STATUS_BEV];
            im  <= wrData[`STATUS_IM];
            ie  <= wrData[`STATUS_IE];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ipHw <= '0;
            ipSw <= '0;
        end else begin
            ipHw <= hwIrq | {timerIrq, 5'b0};   // Timer shares IP7
            if (causeWr)
                ipSw <= wrData[`CAUSE_IP_SW];
        end
    end

    assign ip         = {ipHw, ipSw};
    assign intPending = ie && !exl && |(ip & im);

    noIntInExl: assert property (@(posedge clk) disable iff (!rstN)
        exl |-> !intPending)
        else $error("intPending raised at exception level");

endmodule

// File: verilog/cp0ReadMux.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0ReadMux
    import cp0Pkg::*;
(
    input  regAddr_t   rdAddr,
    input  word_t      count,
    input  word_t      compare,
    input  logic       timerIrq,
    input  logic       exl,
    input  logic       bd,
    input  logic [1:0] ce,
    input  excCode_t   excCode,
    input  word_t      epc,
    input  word_t      badVAddr,
    input  logic [7:0] ip,
    input  logic [7:0] im,
    input  logic       ie,
    input  logic       bev,
    output word_t      rdData
);

    word_t statusWord;
    word_t causeWord;

    always_comb begin
        statusWord = '0;
        statusWord[`STATUS_BEV] = bev;
        statusWord[`STATUS_IM]  = im;
        statusWord[`STATUS_EXL] = exl;
        statusWord[`STATUS_IE]  = ie;

        causeWord = '0;
        causeWord[`CAUSE_BD]      = bd;
        causeWord[`CAUSE_TI]      = timerIrq;
        causeWord[`CAUSE_CE]      = ce;
        causeWord[`CAUSE_IP]      = ip;
        causeWord[`CAUSE_EXCCODE] = excCode;
    end

    always_comb begin
        case (rdAddr)
            `CP0_REG_BADVADDR: rdData = badVAddr;
            `CP0_REG_COUNT:    rdData = count;
            `CP0_REG_COMPARE:  rdData = compare;
            `CP0_REG_STATUS:   rdData = statusWord;
            `CP0_REG_CAUSE:    rdData = causeWord;
            `CP0_REG_EPC:      rdData = epc;
            default:           rdData = '0;   // Unimplemented registers
        endcase
    end

endmodule

// File: verilog/cp0Top.sv
`timescale 1ns/10ps
`include "cp0_cfg.svh"

module cp0Top
    import cp0Pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  hwIrq_t   hwIrq,
    input  regAddr_t rdAddr,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    input  excType_t excType,
    input  word_t    excPc,
    input  logic     excInDelaySlot,
    input  word_t    excBadAddr,
    output word_t    rdData,
    output word_t    epc,
    output logic     statusExl,
    output logic     statusBev,
    output logic     intPending
);

    word_t      count;
    word_t      compare;
    logic       timerIrq;   // Cause.TI
    logic       bd;
    logic [1:0] ce;
    excCode_t   excCode;
    word_t      badVAddr;
    logic [7:0] ip;
    logic [7:0] im;
    logic       ie;

    cp0Timer uTimer (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq)
    );

    cp0Exception uException (
        .clk            (clk),
        .rstN           (rstN),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .excType        (excType),
        .excPc          (excPc),
        .excInDelaySlot (excInDelaySlot),
        .excBadAddr     (excBadAddr),
        .exl            (statusExl),
        .bd             (bd),
        .ce             (ce),
        .excCode        (excCode),
        .epc            (epc),
        .badVAddr       (badVAddr)
    );

    cp0Interrupt uInterrupt (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .hwIrq      (hwIrq),
        .timerIrq   (timerIrq),
        .exl        (statusExl),
        .ip         (ip),
        .im         (im),
        .ie         (ie),
        .bev        (statusBev),
        .intPending (intPending)
    );

    cp0ReadMux uReadMux (
        .rdAddr   (rdAddr),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq),
        .exl      (statusExl),
        .bd       (bd),
        .ce       (ce),
        .excCode  (excCode),
        .epc      (epc),
        .badVAddr (badVAddr),
        .ip       (ip),
        .im       (im),
        .ie       (ie),
        .bev      (statusBev),
        .rdData   (rdData)
    );

endmodule
